// File: hsid_defs.svh
`ifndef HSID_DEFS_SVH
`define HSID_DEFS_SVH

`define HSID_WORD_WIDTH    32  // Input word, two samples side by side
`define HSID_DATA_WIDTH    16  // Unsigned band sample
`define HSID_ACC_WIDTH     48  // Sum of squared differences over one vector
`define HSID_BANDS_WIDTH   6   // Band count, even, up to 62
`define HSID_LIBRARY_WIDTH 6   // Library size and vector index
`define HSID_PACK_WIDTH    5   // Band pairs per vector, bands/2
`define HSID_BUFFER_WIDTH  2   // Reference FIFO address bits, 4 entries

`endif

// File: hsid_pkg.sv
`include "hsid_defs.svh"

package hsid_pkg;

  typedef enum logic [1:0] {
    IDLE,          // Waiting for start
    READ_MEASURE,  // Loading the measured pixel
    COMPUTE_MSE,   // Streaming the library through
    FINISH         // Done pulse
  } hsid_main_state_t;

  typedef struct packed {
    logic [`HSID_DATA_WIDTH-1:0] hi;  // Upper band of the pair
    logic [`HSID_DATA_WIDTH-1:0] lo;  // Lower band of the pair
  } band_pair_t;

  // Same word seen as FIFO payload and as two samples
  typedef union packed {
    logic [`HSID_WORD_WIDTH-1:0] word;   // Raw input word
    band_pair_t                  bands;  // Sample view for the MSE unit
  } band_pack_t;

  typedef struct packed {
    logic [`HSID_WORD_WIDTH-1:0]    value;  // Mean squared error
    logic [`HSID_LIBRARY_WIDTH-1:0] index;  // Library vector it came from
  } mse_result_t;

endpackage

// File: hsid_fifo.sv
`timescale 1ns/1ns

module hsid_fifo #(
  parameter int ADDR_WIDTH = 2  // Depth is 2**ADDR_WIDTH
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 clear,                  // Empties the buffer
  input  logic                 loop_en,                // Read words go back to the tail
  input  logic                 wr_en,
  input  logic                 rd_en,
  input  hsid_pkg::band_pack_t data_in,
  input  logic [ADDR_WIDTH:0]  almost_full_threshold,  // Count that raises almost_full
  output hsid_pkg::band_pack_t data_out,               // Valid one cycle after rd_en
  output logic                 full,
  output logic                 almost_full,
  output logic                 empty
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  hsid_pkg::band_pack_t  mem [DEPTH];
  hsid_pkg::band_pack_t  wr_data;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   count;   // One extra bit to tell full from empty
  logic                  loop_wr; // Recirculating read
  logic                  push;

  assign loop_wr = rd_en & loop_en;
  assign push    = wr_en | loop_wr;
  assign wr_data = loop_wr ? mem[rd_ptr] : data_in;  // Head word rewritten at tail

  assign full        = count[ADDR_WIDTH];  // Count never exceeds DEPTH
  assign empty       = (count == '0);
  assign almost_full = (count >= almost_full_threshold);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en & ~loop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Loop reads keep the count
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out <= '0;
    end else if (rd_en) begin
      data_out <= mem[rd_ptr];  // Registered read port
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> !full && !loop_wr)
    else $error("FIFO write while full or while recirculating");

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    rd_en |-> !empty)
    else $error("FIFO read while empty");

endmodule

// File: hsid_main_fsm.sv
`timescale 1ns/1ns
`include "hsid_defs.svh"

module hsid_main_fsm (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           start,
  input  logic                           hsi_vctr_in_valid,
  input  logic [`HSID_LIBRARY_WIDTH-1:0] library_size_in,
  input  logic [`HSID_BANDS_WIDTH-1:0]   hsi_bands_in,
  input  logic                           fifo_measure_complete,  // Whole pixel stored
  input  logic                           fifo_ref_full,
  input  logic                           fifo_ref_empty,
  input  logic                           mse_busy,               // Hold reads
  input  logic                           mse_comparison_valid,
  output hsid_pkg::hsid_main_state_t     state,
  output logic [`HSID_PACK_WIDTH-1:0]    band_pack_threshold,    // Packs per vector
  output logic                           fifo_both_read_en,
  output logic                           band_pack_valid,
  output logic                           band_pack_start,
  output logic                           band_pack_last,
  output logic [`HSID_LIBRARY_WIDTH-1:0] vctr_ref,
  output logic                           done,
  output logic                           idle,
  output logic                           ready
);

  hsid_pkg::hsid_main_state_t     next_state;
  logic [`HSID_LIBRARY_WIDTH-1:0] library_size;  // Latched at start
  logic [`HSID_PACK_WIDTH-1:0]    wr_pack_cnt;   // Library words accepted in vector
  logic [`HSID_LIBRARY_WIDTH-1:0] wr_vctr_cnt;   // Library vectors accepted
  logic [`HSID_PACK_WIDTH-1:0]    rd_pack_cnt;   // Packs read in vector
  logic [`HSID_LIBRARY_WIDTH-1:0] rd_vctr_cnt;   // Vector being read
  logic [`HSID_LIBRARY_WIDTH-1:0] cmp_cnt;       // Results compared
  logic                           launch;
  logic                           wr_last_pack;
  logic                           rd_last_pack;
  logic                           library_in;
  logic                           last_result;

  assign launch       = idle & start;
  assign wr_last_pack = (wr_pack_cnt == band_pack_threshold - 1'b1);
  assign rd_last_pack = (rd_pack_cnt == band_pack_threshold - 1'b1);
  assign library_in   = (wr_vctr_cnt == library_size);  // Every library word taken
  assign last_result  = (cmp_cnt == library_size - 1'b1);

  assign idle = (state == hsid_pkg::IDLE);
  assign done = (state == hsid_pkg::FINISH);
  assign ready = (state == hsid_pkg::READ_MEASURE && !fifo_measure_complete) ||
                 (state == hsid_pkg::COMPUTE_MSE && !fifo_ref_full && !library_in);
  // Both FIFOs pop together while the pixel loops back for the next vector
  assign fifo_both_read_en = (state == hsid_pkg::COMPUTE_MSE) && !fifo_ref_empty &&
                             !mse_busy;

  always_comb begin
    next_state = state;
    case (state)
      hsid_pkg::IDLE:         if (start) next_state = hsid_pkg::READ_MEASURE;
      hsid_pkg::READ_MEASURE: if (fifo_measure_complete) next_state = hsid_pkg::COMPUTE_MSE;
      hsid_pkg::COMPUTE_MSE:  if (mse_comparison_valid && last_result) begin
        next_state = hsid_pkg::FINISH;
      end
      default:                next_state = hsid_pkg::IDLE;  // FINISH lasts one cycle
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state               <= hsid_pkg::IDLE;
      library_size        <= '0;
      band_pack_threshold <= '0;
    end else begin
      state <= next_state;
      if (launch) begin
        library_size        <= library_size_in;
        band_pack_threshold <= hsi_bands_in[`HSID_BANDS_WIDTH-1:1];  // Two bands a word
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_pack_cnt <= '0;
      wr_vctr_cnt <= '0;
    end else if (launch) begin
      wr_pack_cnt <= '0;
      wr_vctr_cnt <= '0;
    end else if (state == hsid_pkg::COMPUTE_MSE && hsi_vctr_in_valid) begin
      if (wr_last_pack) begin
        wr_pack_cnt <= '0;
        wr_vctr_cnt <= wr_vctr_cnt + 1'b1;
      end else begin
        wr_pack_cnt <= wr_pack_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pack_cnt     <= '0;
      rd_vctr_cnt     <= '0;
      vctr_ref        <= '0;
      band_pack_valid <= 1'b0;
      band_pack_start <= 1'b0;
      band_pack_last  <= 1'b0;
    end else begin
      band_pack_valid <= fifo_both_read_en;  // Aligned with FIFO read data
      band_pack_start <= fifo_both_read_en && (rd_pack_cnt == '0);
      band_pack_last  <= fifo_both_read_en && rd_last_pack;
      if (launch) begin
        rd_pack_cnt <= '0;
        rd_vctr_cnt <= '0;
      end else if (fifo_both_read_en) begin
        vctr_ref <= rd_vctr_cnt;  // Index travels with the packs
        if (rd_last_pack) begin
          rd_pack_cnt <= '0;
          rd_vctr_cnt <= rd_vctr_cnt + 1'b1;
        end else begin
          rd_pack_cnt <= rd_pack_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmp_cnt <= '0;
    end else if (launch) begin
      cmp_cnt <= '0;
    end else if (mse_comparison_valid) begin
      cmp_cnt <= cmp_cnt + 1'b1;
    end
  end

  // Finishing means every library word came in and was read back out
  a_done_complete: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> library_in && fifo_ref_empty)
    else $error("done raised before the whole library was consumed");

endmodule

// File: hsid_mse.sv
`timescale 1ns/1ns
`include "hsid_defs.svh"

module hsid_mse (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           band_pack_valid,
  input  logic                           band_pack_start,  // First pack of a vector
  input  logic                           band_pack_last,   // Last pack of a vector
  input  hsid_pkg::band_pack_t           band_pack_a,      // Measured pixel
  input  hsid_pkg::band_pack_t           band_pack_b,      // Library vector
  input  logic [`HSID_LIBRARY_WIDTH-1:0] vctr_ref,
  input  logic [`HSID_BANDS_WIDTH-1:0]   hsp_bands,        // Divisor, stable during a run
  output logic                           mse_busy,
  output logic                           mse_valid,
  output hsid_pkg::mse_result_t          mse_out
);

  localparam int SQ_WIDTH  = 2 * `HSID_DATA_WIDTH;
  localparam int CNT_WIDTH = $clog2(`HSID_ACC_WIDTH);
  localparam int BW        = `HSID_BANDS_WIDTH;

  logic [`HSID_DATA_WIDTH-1:0]    diff_hi;
  logic [`HSID_DATA_WIDTH-1:0]    diff_lo;
  logic [SQ_WIDTH-1:0]            sq_hi;
  logic [SQ_WIDTH-1:0]            sq_lo;
  logic                           p1_valid;
  logic                           p1_start;
  logic                           p1_last;
  logic [`HSID_LIBRARY_WIDTH-1:0] p1_ref;
  logic [`HSID_ACC_WIDTH-1:0]     acc;
  logic [`HSID_ACC_WIDTH-1:0]     acc_next;
  logic [`HSID_ACC_WIDTH-1:0]     sum;          // Finished sum waiting for the divider
  logic [`HSID_LIBRARY_WIDTH-1:0] sum_ref;
  logic                           sum_pending;
  logic                           div_load;
  logic                           div_busy;
  logic [CNT_WIDTH-1:0]           div_cnt;
  logic [`HSID_ACC_WIDTH-1:0]     div_quo;      // Dividend shifts out, quotient shifts in
  logic [BW-1:0]                  div_rem;
  logic [BW:0]                    rem_shift;
  logic [BW:0]                    rem_diff;
  logic                           rem_fits;
  logic [`HSID_LIBRARY_WIDTH-1:0] div_ref;
  logic [2:0]                     outstanding;  // Finished vectors not yet through divider

  assign diff_hi = (band_pack_a.bands.hi > band_pack_b.bands.hi) ?
                   band_pack_a.bands.hi - band_pack_b.bands.hi :
                   band_pack_b.bands.hi - band_pack_a.bands.hi;
  assign diff_lo = (band_pack_a.bands.lo > band_pack_b.bands.lo) ?
                   band_pack_a.bands.lo - band_pack_b.bands.lo :
                   band_pack_b.bands.lo - band_pack_a.bands.lo;
  assign acc_next = (p1_start ? '0 : acc) + sq_hi + sq_lo;  // Restart on first pack

  // Reads stop once two vectors wait for or sit in the divider
  assign outstanding = {2'b00, band_pack_valid & band_pack_last} + {2'b00, p1_valid & p1_last} +
                       {2'b00, sum_pending} + {2'b00, div_busy};
  assign mse_busy = (outstanding >= 3'd2);
  assign div_load = sum_pending & ~div_busy;

  assign rem_shift = {div_rem, div_quo[`HSID_ACC_WIDTH-1]};
  assign rem_diff  = rem_shift - {1'b0, hsp_bands};
  assign rem_fits  = (rem_shift >= {1'b0, hsp_bands});  // Restoring step

  assign mse_out.value = div_quo[`HSID_WORD_WIDTH-1:0];  // Mean always fits 32 bits
  assign mse_out.index = div_ref;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sq_hi    <= '0;
      sq_lo    <= '0;
      p1_valid <= 1'b0;
      p1_start <= 1'b0;
      p1_last  <= 1'b0;
      p1_ref   <= '0;
    end else begin
      p1_valid <= band_pack_valid;
      p1_start <= band_pack_start;
      p1_last  <= band_pack_last;
      if (band_pack_valid) begin
        sq_hi  <= diff_hi * diff_hi;
        sq_lo  <= diff_lo * diff_lo;
        p1_ref <= vctr_ref;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc         <= '0;
      sum         <= '0;
      sum_ref     <= '0;
      sum_pending <= 1'b0;
    end else begin
      sum_pending <= (p1_valid && p1_last) || (sum_pending && !div_load);
      if (p1_valid) begin
        acc <= acc_next;
        if (p1_last) begin
          sum     <= acc_next;  // Free the accumulator for the next vector
          sum_ref <= p1_ref;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_busy  <= 1'b0;
      div_cnt   <= '0;
      div_quo   <= '0;
      div_rem   <= '0;
      div_ref   <= '0;
      mse_valid <= 1'b0;
    end else begin
      mse_valid <= 1'b0;
      if (div_load) begin
        div_busy <= 1'b1;
        div_cnt  <= '0;
        div_quo  <= sum;
        div_rem  <= '0;
        div_ref  <= sum_ref;
      end else if (div_busy) begin
        div_quo <= {div_quo[`HSID_ACC_WIDTH-2:0], rem_fits};
        div_rem <= rem_fits ? rem_diff[BW-1:0] : rem_shift[BW-1:0];
        div_cnt <= div_cnt + 1'b1;
        if (div_cnt == CNT_WIDTH'(`HSID_ACC_WIDTH - 1)) begin
          div_busy  <= 1'b0;  // One bit per cycle, 48 cycles
          mse_valid <= 1'b1;
        end
      end
    end
  end

  // Relies on the FSM honouring mse_busy
  a_sum_not_lost: assert property (@(posedge clk) disable iff (!arst_n)
    p1_valid && p1_last |-> !(sum_pending && div_busy))
    else $error("vector sum overwritten while waiting for the divider");

endmodule

// File: hsid_mse_comp.sv
`timescale 1ns/1ns

module hsid_mse_comp (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,                 // Forget stored extremes
  input  logic                  mse_valid,
  input  hsid_pkg::mse_result_t mse_in,
  output hsid_pkg::mse_result_t mse_min,
  output hsid_pkg::mse_result_t mse_max,
  output logic                  mse_comparison_valid   // One cycle after mse_valid
);

  logic seeded;  // A result has been seen since clear

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mse_min              <= '0;
      mse_max              <= '0;
      seeded               <= 1'b0;
      mse_comparison_valid <= 1'b0;
    end else begin
      mse_comparison_valid <= mse_valid;
      if (clear) begin
        mse_min <= '0;
        mse_max <= '0;
        seeded  <= 1'b0;
      end else if (mse_valid) begin
        seeded <= 1'b1;
        // Strict compares keep the earlier index on ties
        if (!seeded || mse_in.value < mse_min.value) begin
          mse_min <= mse_in;
        end
        if (!seeded || mse_in.value > mse_max.value) begin
          mse_max <= mse_in;
        end
      end
    end
  end

endmodule

// File: hsid_main.sv
`timescale 1ns/1ns
`include "hsid_defs.svh"

module hsid_main (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           start,
  input  logic                           clear,             // Only while idle
  input  logic                           hsi_vctr_in_valid,
  input  logic [`HSID_WORD_WIDTH-1:0]    hsi_vctr_in,
  input  logic [`HSID_LIBRARY_WIDTH-1:0] library_size_in,
  input  logic [`HSID_BANDS_WIDTH-1:0]   hsi_bands_in,
  output logic [`HSID_WORD_WIDTH-1:0]    mse_min_value,
  output logic [`HSID_WORD_WIDTH-1:0]    mse_max_value,
  output logic [`HSID_LIBRARY_WIDTH-1:0] mse_min_ref,
  output logic [`HSID_LIBRARY_WIDTH-1:0] mse_max_ref,
  output logic                           done,
  output logic                           idle,
  output logic                           ready
);

  localparam int REF_DEPTH = 2 ** `HSID_BUFFER_WIDTH;

  hsid_pkg::hsid_main_state_t     state;
  hsid_pkg::band_pack_t           vctr_word;
  hsid_pkg::band_pack_t           measure_pack;
  hsid_pkg::band_pack_t           ref_pack;
  hsid_pkg::mse_result_t          mse_result;
  hsid_pkg::mse_result_t          mse_min;
  hsid_pkg::mse_result_t          mse_max;
  logic [`HSID_PACK_WIDTH-1:0]    band_pack_threshold;
  logic [`HSID_LIBRARY_WIDTH-1:0] vctr_ref;
  logic fifo_measure_clear;
  logic fifo_measure_wr_en;
  logic fifo_measure_complete;
  logic fifo_ref_wr_en;
  logic fifo_ref_full;
  logic fifo_ref_empty;
  logic fifo_both_read_en;
  logic band_pack_valid;
  logic band_pack_start;
  logic band_pack_last;
  logic mse_busy;
  logic mse_valid;
  logic mse_comparison_valid;

  assign vctr_word          = hsi_vctr_in;
  assign fifo_measure_clear = clear | (idle & start);  // Drop the previous pixel
  assign fifo_measure_wr_en = (state == hsid_pkg::READ_MEASURE) && hsi_vctr_in_valid;
  assign fifo_ref_wr_en     = (state == hsid_pkg::COMPUTE_MSE) && hsi_vctr_in_valid;

  assign mse_min_value = mse_min.value;
  assign mse_min_ref   = mse_min.index;
  assign mse_max_value = mse_max.value;
  assign mse_max_ref   = mse_max.index;

  hsid_main_fsm u_fsm (
    .clk, .arst_n, .start, .hsi_vctr_in_valid, .library_size_in, .hsi_bands_in,
    .fifo_measure_complete, .fifo_ref_full, .fifo_ref_empty, .mse_busy,
    .mse_comparison_valid, .state, .band_pack_threshold, .fifo_both_read_en,
    .band_pack_valid, .band_pack_start, .band_pack_last, .vctr_ref, .done, .idle, .ready
  );

  hsid_fifo #(.ADDR_WIDTH(`HSID_PACK_WIDTH)) u_fifo_measure (
    .clk, .arst_n,
    .clear                 (fifo_measure_clear),
    .loop_en               (1'b1),  // Pixel recirculates for every library vector
    .wr_en                 (fifo_measure_wr_en),
    .rd_en                 (fifo_both_read_en),
    .data_in               (vctr_word),
    .almost_full_threshold ({1'b0, band_pack_threshold}),  // Pixel complete
    .data_out              (measure_pack),
    .full                  (),
    .almost_full           (fifo_measure_complete),
    .empty                 ()
  );

  hsid_fifo #(.ADDR_WIDTH(`HSID_BUFFER_WIDTH)) u_fifo_ref (
    .clk, .arst_n, .clear,
    .loop_en               (1'b0),
    .wr_en                 (fifo_ref_wr_en),
    .rd_en                 (fifo_both_read_en),
    .data_in               (vctr_word),
    .almost_full_threshold ((`HSID_BUFFER_WIDTH + 1)'(REF_DEPTH - 1)),
    .data_out              (ref_pack),
    .full                  (fifo_ref_full),
    .almost_full           (),
    .empty                 (fifo_ref_empty)
  );

  hsid_mse u_mse (
    .clk, .arst_n, .band_pack_valid, .band_pack_start, .band_pack_last,
    .band_pack_a (measure_pack),
    .band_pack_b (ref_pack),
    .vctr_ref,
    .hsp_bands   ({band_pack_threshold, 1'b0}),  // Latched band count
    .mse_busy, .mse_valid,
    .mse_out     (mse_result)
  );

  hsid_mse_comp u_mse_comp (
    .clk, .arst_n, .clear, .mse_valid,
    .mse_in (mse_result),
    .mse_min, .mse_max, .mse_comparison_valid
  );

  // Source may only send while ready is high
  a_valid_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
    hsi_vctr_in_valid |-> ready)
    else $error("input word sent while ready is low");

endmodule

// File: hsid_main_tb.sv
`timescale 1ns/1ns
`include "hsid_defs.svh"

module hsid_main_tb;

  localparam int WAIT_LIMIT = 10000;  // Cycles allowed for any single wait

  logic                           clk;
  logic                           arst_n;
  logic                           start;
  logic                           clear;
  logic                           hsi_vctr_in_valid;
  logic [`HSID_WORD_WIDTH-1:0]    hsi_vctr_in;
  logic [`HSID_LIBRARY_WIDTH-1:0] library_size_in;
  logic [`HSID_BANDS_WIDTH-1:0]   hsi_bands_in;
  logic [`HSID_WORD_WIDTH-1:0]    mse_min_value;
  logic [`HSID_WORD_WIDTH-1:0]    mse_max_value;
  logic [`HSID_LIBRARY_WIDTH-1:0] mse_min_ref;
  logic [`HSID_LIBRARY_WIDTH-1:0] mse_max_ref;
  logic                           done;
  logic                           idle;
  logic                           ready;

  logic [`HSID_WORD_WIDTH-1:0] pixel_mem [0:31];    // Measured pixel, one word per band pair
  logic [`HSID_WORD_WIDTH-1:0] lib_mem   [0:2047];  // Library, vector v at v*packs
  integer      seed;
  int          error_count;
  int          check_count;
  int          timeout_count;
  int          done_count;
  logic        model_seeded;  // Model saw a result since clear
  logic [31:0] model_min_value;
  logic [31:0] model_max_value;
  logic [5:0]  model_min_ref;
  logic [5:0]  model_max_ref;

  hsid_main u_hsid_main (
    .clk, .arst_n, .start, .clear, .hsi_vctr_in_valid, .hsi_vctr_in,
    .library_size_in, .hsi_bands_in, .mse_min_value, .mse_max_value,
    .mse_min_ref, .mse_max_ref, .done, .idle, .ready
  );

  always #5 clk = ~clk;  // 10 ns period

  always @(negedge clk) begin
    if (done) done_count++;  // Pulses per run
  end

  task automatic report_and_finish();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout: %s", what);
    timeout_count++;
    report_and_finish();
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // Sum of squared band differences over the vector, divided by the band count
  function automatic logic [31:0] model_mse(input int v, input int bands);
    longint sum;
    longint a_s;
    longint b_s;
    int     packs;
    sum   = 0;
    packs = bands / 2;
    for (int p = 0; p < packs; p++) begin
      for (int h = 0; h < 2; h++) begin  // Low then high sample
        a_s = (pixel_mem[p] >> (16 * h)) & 16'hffff;
        b_s = (lib_mem[v * packs + p] >> (16 * h)) & 16'hffff;
        sum += (a_s - b_s) * (a_s - b_s);
      end
    end
    return 32'(sum / bands);
  endfunction

  task automatic model_search(input int bands, input int lib_size);
    logic [31:0] mse;
    for (int v = 0; v < lib_size; v++) begin
      mse = model_mse(v, bands);
      if (!model_seeded || mse < model_min_value) begin  // Earlier index wins ties
        model_min_value = mse;
        model_min_ref   = 6'(v);
      end
      if (!model_seeded || mse > model_max_value) begin
        model_max_value = mse;
        model_max_ref   = 6'(v);
      end
      model_seeded = 1'b1;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (!idle && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!idle) timeout_stop("DUT never returned to idle");
  endtask

  task automatic clear_results();
    wait_idle();
    clear = 1'b1;  // Legal only while idle
    @(negedge clk);
    clear        = 1'b0;
    model_seeded = 1'b0;
  endtask

  task automatic send_word(input logic [31:0] word, input int max_gap);
    int gap;
    int cycles;
    gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
    repeat (gap) @(negedge clk);  // Idle cycles between words
    cycles = 0;
    while (!ready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) timeout_stop("ready stayed low while a word was waiting");
    hsi_vctr_in_valid = 1'b1;
    hsi_vctr_in       = word;
    @(negedge clk);
    hsi_vctr_in_valid = 1'b0;
  endtask

  task automatic run_search(input int bands, input int lib_size, input int max_gap);
    int packs;
    int cycles;
    packs = bands / 2;
    wait_idle();
    done_count      = 0;
    hsi_bands_in    = 6'(bands);
    library_size_in = 6'(lib_size);
    start           = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value(ready, 1, "ready after start");
    for (int p = 0; p < packs; p++) send_word(pixel_mem[p], max_gap);
    for (int i = 0; i < lib_size * packs; i++) send_word(lib_mem[i], max_gap);
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) timeout_stop("done never arrived after the last library word");
    model_search(bands, lib_size);
    check_value(mse_min_value, model_min_value, "min value");
    check_value(mse_min_ref, model_min_ref, "min index");
    check_value(mse_max_value, model_max_value, "max value");
    check_value(mse_max_ref, model_max_ref, "max index");
    repeat (8) @(negedge clk);  // Watch for a second done pulse
    check_value(done_count, 1, "done pulses per run");
  endtask

  task automatic fill_random(input int packs, input int lib_size);
    for (int p = 0; p < packs; p++) pixel_mem[p] = $random(seed);
    for (int i = 0; i < packs * lib_size; i++) lib_mem[i] = $random(seed);
  endtask

  task automatic fill_ties();
    int levels [6] = '{5, 1, 9, 1, 5, 9};  // MSE is level squared
    for (int p = 0; p < 2; p++) pixel_mem[p] = '0;
    for (int v = 0; v < 6; v++) begin
      for (int p = 0; p < 2; p++) lib_mem[v * 2 + p] = {16'(levels[v]), 16'(levels[v])};
    end
  endtask

  task automatic test_known_pixel();
    clear_results();
    pixel_mem[0] = {16'd10, 16'd3};
    lib_mem[0]   = {16'd4, 16'd7};  // Diffs 6 and 4, (36+16)/2
    run_search(2, 1, 0);
    check_value(mse_min_value, 26, "known min value");
    check_value(mse_max_value, 26, "known max value");
    check_value(mse_min_ref, 0, "known min index");
    check_value(mse_max_ref, 0, "known max index");
  endtask

  task automatic test_ties();
    clear_results();
    fill_ties();
    run_search(4, 6, 0);
    check_value(mse_min_value, 1, "tie min value");
    check_value(mse_min_ref, 1, "tie min keeps lowest index");
    check_value(mse_max_value, 81, "tie max value");
    check_value(mse_max_ref, 2, "tie max keeps lowest index");
  endtask

  initial begin
    seed              = 32'h23c812d2;
    error_count       = 0;
    check_count       = 0;
    timeout_count     = 0;
    done_count        = 0;
    model_seeded      = 1'b0;
    clk               = 1'b0;
    arst_n            = 1'b0;
    start             = 1'b0;
    clear             = 1'b0;
    hsi_vctr_in_valid = 1'b0;
    hsi_vctr_in       = '0;
    library_size_in   = '0;
    hsi_bands_in      = '0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    check_value(idle, 1, "idle after reset");
    check_value(done, 0, "done after reset");
    check_value(ready, 0, "ready after reset");
    test_known_pixel();
    clear_results();
    fill_random(8, 8);
    run_search(16, 8, 0);    // Back to back
    clear_results();
    run_search(16, 8, 3);    // Same data with gaps
    clear_results();
    fill_random(1, 20);
    run_search(2, 20, 0);    // Short vectors stall the divider
    test_ties();
    fill_random(2, 10);
    run_search(4, 10, 2);    // No clear, extremes span both runs
    test_ties();             // Clear first, only the new library counts
    report_and_finish();
  end

endmodule

// File: filelist.f
+incdir+.
hsid_pkg.sv
hsid_fifo.sv
hsid_main_fsm.sv
hsid_mse.sv
hsid_mse_comp.sv
hsid_main.sv
hsid_main_tb.sv
